/* bench/cpuCtrlStim.txt */
// instr flags(bit2 carry, bit1 zero, bit0 negative) regSel aluMode srcB dataSel dAddrSel iAddrSel en
// en bits 7..0: regWrite incPair decPair dMemWrite dMemRead flagEn iMemRead pcWrite
5a37 0 5 3 2 2 0 1 87   // alu immediate, mode 3
1728 0 7 5 0 2 0 1 87   // alu register, mode 5
0b60 0 b c 0 2 0 1 87
3a12 0 3 0 0 2 1 1 08   // in, read cycle
3a12 0 3 0 0 2 1 1 8b
4c54 0 4 0 0 2 1 1 13   // out
2568 0 4 d 0 2 0 1 13   // st
3670 0 6 d 0 2 0 1 53   // sti
3478 0 4 d 0 2 0 1 33   // std
1a88 0 a 0 0 2 0 1 08   // ldi
1a88 0 a 0 0 2 0 1 cb
2290 0 2 0 0 2 0 1 08   // ldd
2290 0 2 0 0 2 0 1 ab
0480 0 4 0 0 2 0 1 08   // ld
0480 0 4 0 0 2 0 1 8b
0698 0 6 0 0 2 0 1 43   // pair increment
08a0 0 8 0 0 2 0 1 23   // pair decrement
0ca8 0 c 0 0 2 0 4 03   // pair jump, all eight conditions
2ca8 0 2 0 0 2 0 1 03
2ca8 4 c 0 0 2 0 4 03
4ca8 0 c 0 0 2 0 4 03
6ca8 2 c 0 0 2 0 4 03
8ca8 2 8 0 0 2 0 1 03
aca8 0 a 0 0 2 0 1 03
cca8 0 c 0 0 2 0 4 03
eca8 7 c 0 0 2 0 4 03
02b0 0 0 0 0 2 0 1 03   // jmp taken
3000 0 3 0 0 2 0 3 03   // jump target word
60b0 0 6 0 0 2 0 0 03   // jmp skipped
20b8 4 e 0 0 1 0 1 32   // call taken, low byte
e000 4 e 0 0 0 0 3 33   // call target word, high byte
40b8 4 e 0 0 2 0 0 03   // call skipped
a0c0 1 e 0 0 2 2 5 48   // ret taken
a0c0 1 e 0 0 2 2 5 48
a0c0 1 e 0 0 2 2 5 0b
c0c0 1 e 0 0 2 0 1 03   // ret skipped
50c8 0 5 0 0 2 0 1 03   // former status op
0000 0 0 0 0 2 0 1 03   // nop
00e8 0 0 0 0 2 0 1 00   // hlt
00e8 0 0 0 0 2 0 1 00
00e8 0 0 0 0 2 0 1 00
0000 0 0 0 0 2 0 1 03

/* bench/cpuCtrlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCtrlTb;

    localparam int    RESET_CYCLES = 8;
    localparam int    FIELDS       = 9;         // words per stimulus line
    localparam int    MEM_WORDS    = 1024;
    localparam int    MAX_VEC      = MEM_WORDS / FIELDS;
    localparam string STIM_FILE    = "bench/cpuCtrlStim.txt";

    logic                    clk;
    logic                    rstN;
    ctrlIsaPkg::instrT       iMemOut;
    logic                    carryFlag;
    logic                    zeroFlag;
    logic                    negativeFlag;
    ctrlIsaPkg::regSelT      regFileOutBSelect;
    logic                    regFileWriteEnable;
    logic                    regFileIncPair;
    logic                    regFileDecPair;
    ctrlSigPkg::aluSrcBSelT  aluSrcBSelect;
    ctrlSigPkg::aluModeT     aluMode;
    ctrlSigPkg::dMemDataSelT dMemDataSelect;
    ctrlSigPkg::dMemAddrSelT dMemAddressSelect;
    logic                    dMemWriteEn;
    logic                    dMemReadEn;
    logic                    flagEnable;
    ctrlSigPkg::iMemAddrSelT iMemAddrSelect;
    logic                    iMemReadEnable;
    logic                    pcWriteEn;

    logic [15:0] stim [0:MEM_WORDS-1];
    int          numVec;
    int          errors;
    int          cycleCount = 0;
    int          cycleLimit = MAX_VEC + RESET_CYCLES + 20;

    cpuCtrl DUT (
        .clk                (clk),
        .rstN               (rstN),
        .iMemOut            (iMemOut),
        .carryFlag          (carryFlag),
        .zeroFlag           (zeroFlag),
        .negativeFlag       (negativeFlag),
        .regFileOutBSelect  (regFileOutBSelect),
        .regFileWriteEnable (regFileWriteEnable),
        .regFileIncPair     (regFileIncPair),
        .regFileDecPair     (regFileDecPair),
        .aluSrcBSelect      (aluSrcBSelect),
        .aluMode            (aluMode),
        .dMemDataSelect     (dMemDataSelect),
        .dMemAddressSelect  (dMemAddressSelect),
        .dMemWriteEn        (dMemWriteEn),
        .dMemReadEn         (dMemReadEn),
        .flagEnable         (flagEnable),
        .iMemAddrSelect     (iMemAddrSelect),
        .iMemReadEnable     (iMemReadEnable),
        .pcWriteEn          (pcWriteEn)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = !clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout after %0d clock cycles, the run did not finish", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic checkRegSel(input string name, input ctrlIsaPkg::regSelT actual,
                               input ctrlIsaPkg::regSelT expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic checkAluMode(input string name, input ctrlSigPkg::aluModeT actual,
                                input ctrlSigPkg::aluModeT expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic checkSrcBSel(input string name, input ctrlSigPkg::aluSrcBSelT actual,
                                input ctrlSigPkg::aluSrcBSelT expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic checkDataSel(input string name, input ctrlSigPkg::dMemDataSelT actual,
                                input ctrlSigPkg::dMemDataSelT expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic checkDAddrSel(input string name, input ctrlSigPkg::dMemAddrSelT actual,
                                 input ctrlSigPkg::dMemAddrSelT expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic checkIAddrSel(input string name, input ctrlSigPkg::iMemAddrSelT actual,
                                 input ctrlSigPkg::iMemAddrSelT expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic checkEnable(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s is %0b, expected %0b", $time, name, actual, expected);
        end
    endtask

    task automatic checkEnables(input logic [7:0] en);
        checkEnable("regFileWriteEnable", regFileWriteEnable, en[7]);
        checkEnable("regFileIncPair", regFileIncPair, en[6]);
        checkEnable("regFileDecPair", regFileDecPair, en[5]);
        checkEnable("dMemWriteEn", dMemWriteEn, en[4]);
        checkEnable("dMemReadEn", dMemReadEn, en[3]);
        checkEnable("flagEnable", flagEnable, en[2]);
        checkEnable("iMemReadEnable", iMemReadEnable, en[1]);
        checkEnable("pcWriteEn", pcWriteEn, en[0]);
    endtask

    task automatic loadStimulus(output bit ok);
        int fd;
        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
        end else begin
            $fclose(fd);
            for (int i = 0; i < MEM_WORDS; i++) begin
                stim[i] = 16'hffff;             // marks unused lines
            end
            $readmemh(STIM_FILE, stim);
            numVec = 0;
            while (numVec < MAX_VEC && stim[numVec * FIELDS + 2] != 16'hffff) begin
                numVec++;
            end
            if (numVec == 0) begin
                $display("stimulus file %s holds no vectors", STIM_FILE);
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    // every enable must stay low while reset is held
    task automatic applyReset;
        rstN = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #90;
            checkEnables(8'h00);
        end
    endtask

    task automatic driveVector(input int n);
        int base;
        base         = n * FIELDS;
        iMemOut      = stim[base];
        carryFlag    = stim[base + 1][2];
        zeroFlag     = stim[base + 1][1];
        negativeFlag = stim[base + 1][0];
    endtask

    task automatic checkVector(input int n);
        int base;
        base = n * FIELDS;
        checkRegSel("regFileOutBSelect", regFileOutBSelect,
                    ctrlIsaPkg::regSelT'(stim[base + 2][3:0]));
        checkAluMode("aluMode", aluMode, ctrlSigPkg::aluModeT'(stim[base + 3][3:0]));
        checkSrcBSel("aluSrcBSelect", aluSrcBSelect,
                     ctrlSigPkg::aluSrcBSelT'(stim[base + 4][1:0]));
        checkDataSel("dMemDataSelect", dMemDataSelect,
                     ctrlSigPkg::dMemDataSelT'(stim[base + 5][1:0]));
        checkDAddrSel("dMemAddressSelect", dMemAddressSelect,
                      ctrlSigPkg::dMemAddrSelT'(stim[base + 6][1:0]));
        checkIAddrSel("iMemAddrSelect", iMemAddrSelect,
                      ctrlSigPkg::iMemAddrSelT'(stim[base + 7][2:0]));
        checkEnables(stim[base + 8][7:0]);
    endtask

    initial begin
        bit loaded;
        rstN         = 1'b0;
        iMemOut      = '0;
        carryFlag    = 1'b0;
        zeroFlag     = 1'b0;
        negativeFlag = 1'b0;
        errors       = 0;
        numVec       = 0;
        loadStimulus(loaded);
        if (!loaded) begin
            $display("Simulation failed");
            $finish;
        end else begin
            cycleLimit = numVec + RESET_CYCLES + 20;
            applyReset();
            for (int n = 0; n < numVec; n++) begin
                @(posedge clk);
                #5;                             // drive just after the edge
                rstN = 1'b1;
                driveVector(n);
                #90;                            // sample just before the next edge
                checkVector(n);
            end
            $display("%0d vectors checked, %0d errors", numVec, errors);
            if (errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* build.sh */
#!/usr/bin/env bash
# Compile and run the cpuCtrl testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f cpuCtrl.f --top-module cpuCtrlTb -o cpuCtrlSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/cpuCtrlSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
    exit 0
else
    exit 1
fi

/* cpuCtrl.f */
+incdir+source
source/ctrlIsaPkg.sv
source/ctrlSigPkg.sv
source/instrDecode.sv
source/ctrlSequencer.sv
source/ctrlEncode.sv
source/cpuCtrl.sv
bench/cpuCtrlTb.sv

/* source/cpuCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCtrl (
    input  logic                    clk,
    input  logic                    rstN,
    input  ctrlIsaPkg::instrT       iMemOut,
    input  logic                    carryFlag,
    input  logic                    zeroFlag,
    input  logic                    negativeFlag,
    output ctrlIsaPkg::regSelT      regFileOutBSelect,
    output logic                    regFileWriteEnable,
    output logic                    regFileIncPair,
    output logic                    regFileDecPair,
    output ctrlSigPkg::aluSrcBSelT  aluSrcBSelect,
    output ctrlSigPkg::aluModeT     aluMode,
    output ctrlSigPkg::dMemDataSelT dMemDataSelect,
    output ctrlSigPkg::dMemAddrSelT dMemAddressSelect,
    output logic                    dMemWriteEn,
    output logic                    dMemReadEn,
    output logic                    flagEnable,
    output ctrlSigPkg::iMemAddrSelT iMemAddrSelect,
    output logic                    iMemReadEnable,
    output logic                    pcWriteEn
);

    ctrlIsaPkg::opClassT  opClass;
    ctrlIsaPkg::pairOpT   pairOp;
    ctrlSigPkg::aluModeT  aluField;
    ctrlSigPkg::ctrlStepT step;

    instrDecode uDecode (
        .iMemOut           (iMemOut),
        .carryFlag         (carryFlag),
        .zeroFlag          (zeroFlag),
        .negativeFlag      (negativeFlag),
        .opClass           (opClass),
        .pairOp            (pairOp),
        .aluField          (aluField),
        .regFileOutBSelect (regFileOutBSelect)
    );

    ctrlSequencer uSeq (
        .clk     (clk),
        .rstN    (rstN),
        .opClass (opClass),
        .step    (step)
    );

    ctrlEncode uEncode (
        .step               (step),
        .pairOp             (pairOp),
        .aluField           (aluField),
        .regFileWriteEnable (regFileWriteEnable),
        .regFileIncPair     (regFileIncPair),
        .regFileDecPair     (regFileDecPair),
        .aluSrcBSelect      (aluSrcBSelect),
        .aluMode            (aluMode),
        .dMemDataSelect     (dMemDataSelect),
        .dMemAddressSelect  (dMemAddressSelect),
        .dMemWriteEn        (dMemWriteEn),
        .dMemReadEn         (dMemReadEn),
        .flagEnable         (flagEnable),
        .iMemAddrSelect     (iMemAddrSelect),
        .iMemReadEnable     (iMemReadEnable),
        .pcWriteEn          (pcWriteEn)
    );

endmodule

`default_nettype wire

/* source/cpuCtrl_consts.svh */
`ifndef CPUCTRL_CONSTS_SVH
`define CPUCTRL_CONSTS_SVH

// instruction word layout
`define INSTR_W      16
`define REG_SEL_W    4
`define OPC_LSB      3
`define OPC_MSB      7
`define COND_LSB     13     // 3-bit condition up to the msb

`define SP_LOW_REG   14     // low half of the stack pointer pair

// alu modes the control unit forces itself
`define ALU_PASS_A   13
`define ALU_PASS_B   0

// opcode numbers in bits 7..3 when the low bits are 000
`define OPC_RR_FIRST 1
`define OPC_RR_LAST  12
`define OPC_ST       13
`define OPC_STI      14
`define OPC_STD      15
`define OPC_LD       16
`define OPC_LDI      17
`define OPC_LDD      18
`define OPC_PINC     19
`define OPC_PDEC     20
`define OPC_PJMP     21
`define OPC_JMP      22
`define OPC_CALL     23
`define OPC_RET      24
`define OPC_HLT      29

`endif

/* source/ctrlEncode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuCtrl_consts.svh"

module ctrlEncode (
    input  ctrlSigPkg::ctrlStepT    step,
    input  ctrlIsaPkg::pairOpT      pairOp,
    input  ctrlSigPkg::aluModeT     aluField,
    output logic                    regFileWriteEnable,
    output logic                    regFileIncPair,
    output logic                    regFileDecPair,
    output ctrlSigPkg::aluSrcBSelT  aluSrcBSelect,
    output ctrlSigPkg::aluModeT     aluMode,
    output ctrlSigPkg::dMemDataSelT dMemDataSelect,
    output ctrlSigPkg::dMemAddrSelT dMemAddressSelect,
    output logic                    dMemWriteEn,
    output logic                    dMemReadEn,
    output logic                    flagEnable,
    output ctrlSigPkg::iMemAddrSelT iMemAddrSelect,
    output logic                    iMemReadEnable,
    output logic                    pcWriteEn
);

    // steps that keep the current instruction word on iMemOut
    assign iMemReadEnable = !(step inside {ctrlSigPkg::stepInRead, ctrlSigPkg::stepLoadRead,
                                           ctrlSigPkg::stepRetPop, ctrlSigPkg::stepRetInc,
                                           ctrlSigPkg::stepHalt, ctrlSigPkg::stepReset});

    // steps that leave the program counter alone
    assign pcWriteEn = !(step inside {ctrlSigPkg::stepInRead, ctrlSigPkg::stepLoadRead,
                                      ctrlSigPkg::stepCallLow, ctrlSigPkg::stepRetPop,
                                      ctrlSigPkg::stepRetInc, ctrlSigPkg::stepHalt,
                                      ctrlSigPkg::stepReset});

    always_comb begin
        regFileWriteEnable = 1'b0;
        regFileIncPair     = 1'b0;
        regFileDecPair     = 1'b0;
        aluSrcBSelect      = ctrlSigPkg::regB;
        aluMode            = ctrlSigPkg::aluModeT'(`ALU_PASS_B);
        dMemDataSelect     = ctrlSigPkg::aluOut;
        dMemAddressSelect  = ctrlSigPkg::pairAddr;
        dMemWriteEn        = 1'b0;
        dMemReadEn         = 1'b0;
        flagEnable         = 1'b0;
        iMemAddrSelect     = ctrlSigPkg::pcOut;
        case (step)
            ctrlSigPkg::stepAluImm: begin
                regFileWriteEnable = 1'b1;
                flagEnable         = 1'b1;
                aluMode            = aluField;
                aluSrcBSelect      = ctrlSigPkg::imm8;
            end
            ctrlSigPkg::stepAluReg: begin
                regFileWriteEnable = 1'b1;
                flagEnable         = 1'b1;
                aluMode            = aluField;
            end
            ctrlSigPkg::stepInRead: begin
                dMemReadEn        = 1'b1;
                dMemAddressSelect = ctrlSigPkg::portAddr;
            end
            ctrlSigPkg::stepInWrite: begin
                regFileWriteEnable = 1'b1;
                dMemReadEn         = 1'b1;
                dMemAddressSelect  = ctrlSigPkg::portAddr;
            end
            ctrlSigPkg::stepOut: begin
                dMemWriteEn       = 1'b1;
                dMemAddressSelect = ctrlSigPkg::portAddr;
            end
            ctrlSigPkg::stepStore: begin
                dMemWriteEn    = 1'b1;
                aluMode        = ctrlSigPkg::aluModeT'(`ALU_PASS_A);  // data reg onto aluOut
                regFileIncPair = (pairOp == ctrlIsaPkg::pairInc);
                regFileDecPair = (pairOp == ctrlIsaPkg::pairDec);
            end
            ctrlSigPkg::stepLoadRead: dMemReadEn = 1'b1;
            ctrlSigPkg::stepLoadWrite: begin
                regFileWriteEnable = 1'b1;
                dMemReadEn         = 1'b1;
                regFileIncPair     = (pairOp == ctrlIsaPkg::pairInc);   // post-modify once
                regFileDecPair     = (pairOp == ctrlIsaPkg::pairDec);
            end
            ctrlSigPkg::stepPairInc: regFileIncPair = 1'b1;
            ctrlSigPkg::stepPairDec: regFileDecPair = 1'b1;
            ctrlSigPkg::stepPairJmp: iMemAddrSelect = ctrlSigPkg::pairJump;
            ctrlSigPkg::stepJmpSkip, ctrlSigPkg::stepCallSkip:
                iMemAddrSelect = ctrlSigPkg::pcPlusOne;     // step over the target word
            ctrlSigPkg::stepJmpLoad: iMemAddrSelect = ctrlSigPkg::iMemOut;
            ctrlSigPkg::stepCallLow: begin
                dMemDataSelect = ctrlSigPkg::pcLow;
                dMemWriteEn    = 1'b1;
                regFileDecPair = 1'b1;
            end
            ctrlSigPkg::stepCallHigh: begin
                dMemDataSelect = ctrlSigPkg::pcHigh;
                dMemWriteEn    = 1'b1;
                regFileDecPair = 1'b1;
                iMemAddrSelect = ctrlSigPkg::iMemOut;
            end
            ctrlSigPkg::stepRetPop, ctrlSigPkg::stepRetInc: begin
                dMemAddressSelect = ctrlSigPkg::spPlusOne;
                dMemReadEn        = 1'b1;
                regFileIncPair    = 1'b1;                   // pop one byte per cycle
                iMemAddrSelect    = ctrlSigPkg::returnAddr;
            end
            ctrlSigPkg::stepRetLoad: begin
                dMemAddressSelect = ctrlSigPkg::spPlusOne;
                dMemReadEn        = 1'b1;
                iMemAddrSelect    = ctrlSigPkg::returnAddr;
            end
            default: ;      // halt and reset keep the idle values
        endcase
    end

    always_comb begin
        pairExclusive: assert final (!(regFileIncPair && regFileDecPair));
        pcNeedsFetch: assert final (!pcWriteEn || iMemReadEnable);
    end

endmodule

`default_nettype wire

/* source/ctrlIsaPkg.sv */
`default_nettype none

`include "cpuCtrl_consts.svh"

package ctrlIsaPkg;

    typedef logic [`INSTR_W-1:0]   instrT;
    typedef logic [`REG_SEL_W-1:0] regSelT;

    typedef enum logic [4:0] {
        clsAluImm,
        clsAluReg,
        clsIn,
        clsOut,
        clsStore,
        clsLoad,
        clsPairInc,
        clsPairDec,
        clsPairJmp,
        clsJmpTaken,
        clsJmpSkip,
        clsCallTaken,
        clsCallSkip,
        clsRetTaken,
        clsRetSkip,
        clsHalt,
        clsNop                      // also the dropped status opcodes
    } opClassT;

    typedef enum logic [1:0] {
        pairNone,
        pairInc,
        pairDec
    } pairOpT;

    // encoding of bits 15..13
    typedef enum logic [2:0] {
        condAlways,
        condCarrySet,
        condCarryClr,
        condZeroSet,
        condZeroClr,
        condNegSet,
        condNegClr,
        condAlwaysAlt
    } condT;

endpackage

`default_nettype wire

/* source/ctrlSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlSequencer (
    input  logic                 clk,
    input  logic                 rstN,
    input  ctrlIsaPkg::opClassT  opClass,
    output ctrlSigPkg::ctrlStepT step
);

    ctrlSigPkg::ctrlStateT state;
    ctrlSigPkg::ctrlStateT nextState;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= ctrlSigPkg::stFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = ctrlSigPkg::stFetch;
        step      = ctrlSigPkg::stepNop;
        case (state)
            ctrlSigPkg::stFetch: begin
                case (opClass)
                    ctrlIsaPkg::clsAluImm:  step = ctrlSigPkg::stepAluImm;
                    ctrlIsaPkg::clsAluReg:  step = ctrlSigPkg::stepAluReg;
                    ctrlIsaPkg::clsIn: begin
                        step      = ctrlSigPkg::stepInRead;
                        nextState = ctrlSigPkg::stReadWait;
                    end
                    ctrlIsaPkg::clsOut:     step = ctrlSigPkg::stepOut;
                    ctrlIsaPkg::clsStore:   step = ctrlSigPkg::stepStore;
                    ctrlIsaPkg::clsLoad: begin
                        step      = ctrlSigPkg::stepLoadRead;
                        nextState = ctrlSigPkg::stReadWait;
                    end
                    ctrlIsaPkg::clsPairInc: step = ctrlSigPkg::stepPairInc;
                    ctrlIsaPkg::clsPairDec: step = ctrlSigPkg::stepPairDec;
                    ctrlIsaPkg::clsPairJmp: step = ctrlSigPkg::stepPairJmp;
                    ctrlIsaPkg::clsJmpTaken: begin
                        step      = ctrlSigPkg::stepJmpWait;
                        nextState = ctrlSigPkg::stJumpTarget;
                    end
                    ctrlIsaPkg::clsJmpSkip: step = ctrlSigPkg::stepJmpSkip;
                    ctrlIsaPkg::clsCallTaken: begin
                        step      = ctrlSigPkg::stepCallLow;
                        nextState = ctrlSigPkg::stCallHigh;
                    end
                    ctrlIsaPkg::clsCallSkip: step = ctrlSigPkg::stepCallSkip;
                    ctrlIsaPkg::clsRetTaken: begin
                        step      = ctrlSigPkg::stepRetPop;
                        nextState = ctrlSigPkg::stReadWait;
                    end
                    ctrlIsaPkg::clsRetSkip: step = ctrlSigPkg::stepRetSkip;
                    ctrlIsaPkg::clsHalt:    step = ctrlSigPkg::stepHalt;
                    default:                step = ctrlSigPkg::stepNop;
                endcase
            end
            ctrlSigPkg::stJumpTarget: step = ctrlSigPkg::stepJmpLoad;    // word 2 is the target
            ctrlSigPkg::stCallHigh:   step = ctrlSigPkg::stepCallHigh;
            ctrlSigPkg::stReadWait: begin
                // instruction word is held, so the class is still valid here
                if (opClass == ctrlIsaPkg::clsIn) begin
                    step = ctrlSigPkg::stepInWrite;
                end else if (opClass == ctrlIsaPkg::clsLoad) begin
                    step = ctrlSigPkg::stepLoadWrite;
                end else begin
                    step      = ctrlSigPkg::stepRetInc;
                    nextState = ctrlSigPkg::stRetLoad;
                end
            end
            ctrlSigPkg::stRetLoad: step = ctrlSigPkg::stepRetLoad;
            default:               step = ctrlSigPkg::stepNop;
        endcase
        if (!rstN) begin
            step = ctrlSigPkg::stepReset;
        end
    end

    stateLegal: assert property (@(posedge clk) disable iff (!rstN)
        state inside {ctrlSigPkg::stFetch, ctrlSigPkg::stJumpTarget, ctrlSigPkg::stCallHigh,
                      ctrlSigPkg::stReadWait, ctrlSigPkg::stRetLoad});

    // second words are single cycle
    secondWordDone: assert property (@(posedge clk) disable iff (!rstN)
        state inside {ctrlSigPkg::stCallHigh, ctrlSigPkg::stJumpTarget}
        |=> state == ctrlSigPkg::stFetch);

endmodule

`default_nettype wire

/* source/ctrlSigPkg.sv */
`default_nettype none

package ctrlSigPkg;

    typedef logic [3:0] aluModeT;

    typedef enum logic [1:0] {
        regB = 2'd0,
        imm8 = 2'd2
    } aluSrcBSelT;

    typedef enum logic [1:0] {
        pcHigh = 2'd0,
        pcLow  = 2'd1,
        aluOut = 2'd2
    } dMemDataSelT;

    typedef enum logic [1:0] {
        pairAddr  = 2'd0,
        portAddr  = 2'd1,           // 8-bit port number from the instruction
        spPlusOne = 2'd2
    } dMemAddrSelT;

    typedef enum logic [2:0] {
        pcPlusOne  = 3'd0,
        pcOut      = 3'd1,
        iMemOut    = 3'd3,          // second word of JMP and CALL
        pairJump   = 3'd4,
        returnAddr = 3'd5
    } iMemAddrSelT;

    typedef enum logic [2:0] {
        stFetch,
        stJumpTarget,
        stCallHigh,
        stReadWait,
        stRetLoad
    } ctrlStateT;

    typedef enum logic [4:0] {
        stepReset, stepAluImm, stepAluReg,
        stepInRead, stepInWrite, stepOut,
        stepStore, stepLoadRead, stepLoadWrite,
        stepPairInc, stepPairDec, stepPairJmp,
        stepJmpWait, stepJmpSkip, stepJmpLoad,
        stepCallLow, stepCallHigh, stepCallSkip,
        stepRetPop, stepRetInc, stepRetLoad, stepRetSkip,
        stepHalt, stepNop
    } ctrlStepT;

endpackage

`default_nettype wire

/* source/instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuCtrl_consts.svh"

module instrDecode (
    input  ctrlIsaPkg::instrT   iMemOut,
    input  logic                carryFlag,
    input  logic                zeroFlag,
    input  logic                negativeFlag,
    output ctrlIsaPkg::opClassT opClass,
    output ctrlIsaPkg::pairOpT  pairOp,
    output ctrlSigPkg::aluModeT aluField,
    output ctrlIsaPkg::regSelT  regFileOutBSelect
);

    logic [`OPC_MSB-`OPC_LSB:0] opcode;
    ctrlIsaPkg::condT           cond;
    logic                       condMet;

    assign opcode = iMemOut[`OPC_MSB:`OPC_LSB];
    assign cond   = ctrlIsaPkg::condT'(iMemOut[`INSTR_W-1:`COND_LSB]);

    always_comb begin
        case (cond)
            ctrlIsaPkg::condCarrySet: condMet = carryFlag;
            ctrlIsaPkg::condCarryClr: condMet = !carryFlag;
            ctrlIsaPkg::condZeroSet:  condMet = zeroFlag;
            ctrlIsaPkg::condZeroClr:  condMet = !zeroFlag;
            ctrlIsaPkg::condNegSet:   condMet = negativeFlag;
            ctrlIsaPkg::condNegClr:   condMet = !negativeFlag;
            default:                  condMet = 1'b1;   // codes 0 and 7
        endcase
    end

    always_comb begin
        opClass  = ctrlIsaPkg::clsNop;
        pairOp   = ctrlIsaPkg::pairNone;
        aluField = iMemOut[6:3];
        if (iMemOut[0] && iMemOut[3:1] != 3'b111) begin
            opClass  = ctrlIsaPkg::clsAluImm;
            aluField = {1'b0, iMemOut[3:1]};
        end else if (iMemOut[2:0] == 3'b010) begin
            opClass = ctrlIsaPkg::clsIn;
        end else if (iMemOut[2:0] == 3'b100) begin
            opClass = ctrlIsaPkg::clsOut;
        end else if (iMemOut[2:0] == 3'b000) begin
            case (opcode) inside
                [`OPC_RR_FIRST:`OPC_RR_LAST]: opClass = ctrlIsaPkg::clsAluReg;
                [`OPC_ST:`OPC_LDD]: begin
                    opClass = (opcode <= `OPC_STD) ? ctrlIsaPkg::clsStore : ctrlIsaPkg::clsLoad;
                    if (opcode == `OPC_STI || opcode == `OPC_LDI) begin
                        pairOp = ctrlIsaPkg::pairInc;
                    end else if (opcode == `OPC_STD || opcode == `OPC_LDD) begin
                        pairOp = ctrlIsaPkg::pairDec;
                    end
                end
                `OPC_PINC: opClass = ctrlIsaPkg::clsPairInc;
                `OPC_PDEC: opClass = ctrlIsaPkg::clsPairDec;
                `OPC_PJMP: opClass = condMet ? ctrlIsaPkg::clsPairJmp : ctrlIsaPkg::clsNop;
                `OPC_JMP:  opClass = condMet ? ctrlIsaPkg::clsJmpTaken : ctrlIsaPkg::clsJmpSkip;
                `OPC_CALL: opClass = condMet ? ctrlIsaPkg::clsCallTaken : ctrlIsaPkg::clsCallSkip;
                `OPC_RET:  opClass = condMet ? ctrlIsaPkg::clsRetTaken : ctrlIsaPkg::clsRetSkip;
                `OPC_HLT:  opClass = ctrlIsaPkg::clsHalt;
                default:   opClass = ctrlIsaPkg::clsNop;    // status ops land here
            endcase
        end
    end

    always_comb begin
        case (opClass)
            ctrlIsaPkg::clsAluReg: regFileOutBSelect = iMemOut[11:8];
            ctrlIsaPkg::clsStore, ctrlIsaPkg::clsLoad, ctrlIsaPkg::clsPairInc,
            ctrlIsaPkg::clsPairDec, ctrlIsaPkg::clsPairJmp:
                regFileOutBSelect = {iMemOut[11:9], 1'b0};  // even register of the pair
            ctrlIsaPkg::clsCallTaken, ctrlIsaPkg::clsCallSkip,
            ctrlIsaPkg::clsRetTaken, ctrlIsaPkg::clsRetSkip:
                regFileOutBSelect = ctrlIsaPkg::regSelT'(`SP_LOW_REG);
            default: regFileOutBSelect = iMemOut[15:12];
        endcase
    end

endmodule

`default_nettype wire
